// File: hdl/slam_pkg.sv
package slam_pkg;

  // Q16.16 signed position or distance
  typedef logic signed [31:0] coord_t;
  // binary angle, full turn is 2^32
  typedef logic [31:0] angle_t;
  typedef logic [4:0] mem_addr_t;
  typedef logic [3:0] lm_count_t;

  localparam lm_count_t MAX_LANDMARKS = 4'd8;

  // state vector memory map
  localparam mem_addr_t ADDR_X       = 5'd0;
  localparam mem_addr_t ADDR_Y       = 5'd1;
  localparam mem_addr_t ADDR_THETA   = 5'd2;
  localparam mem_addr_t ADDR_LM_BASE = 5'd3;
  localparam int STATE_WORDS = 19;

  localparam int CORDIC_ITER = 16;
  // 1/K in Q1.16, about 0.60725
  localparam logic [16:0] CORDIC_GAIN_INV = 17'd39797;

  typedef enum logic [2:0] {
    STAGE_IDLE  = 3'd0,
    STAGE_PRD   = 3'd1,
    STAGE_NEW   = 3'd2,
    STAGE_UPD   = 3'd3,
    STAGE_ASSOC = 3'd4
  } stage_t;

  // one requester's access to the state ram
  typedef struct packed {
    logic      en;
    logic      we;
    mem_addr_t addr;
    coord_t    wdata;
  } mem_req_t;

  // rotator operand
  typedef struct packed {
    coord_t mag;
    angle_t ang;
  } rot_req_t;

endpackage

// File: hdl/state_ram.sv
module state_ram
  import slam_pkg::*;
(
  input  logic     clk,
  input  mem_req_t ram_req,
  output coord_t   ram_rdata
);

  // pose words then landmark pairs
  coord_t mem [STATE_WORDS];

  // one port, a write returns no data
  always_ff @(posedge clk) begin
    if (ram_req.en) begin
      if (ram_req.we) begin
        mem[ram_req.addr] <= ram_req.wdata;
      end else begin
        ram_rdata <= mem[ram_req.addr];
      end
    end
  end

endmodule

// File: hdl/state_mem_arbiter.sv
module state_mem_arbiter
  import slam_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rst,
  input  mem_req_t eng_req,
  input  mem_req_t rd_req,
  output logic     eng_gnt,
  output logic     rd_gnt,
  output mem_req_t ram_req
);

  logic eng_prev_q;

  // engine used the port in the previous cycle
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      eng_prev_q <= 1'b0;
    end else begin
      eng_prev_q <= eng_req.en;
    end
  end

  // engine always wins
  assign eng_gnt = eng_req.en;

  // readout also yields for one cycle after an engine access,
  // so a stage's read and write bursts stay back to back
  assign rd_gnt = rd_req.en && !eng_req.en && !eng_prev_q;

  always_comb begin
    ram_req = '0;
    if (eng_gnt) begin
      ram_req = eng_req;
    end else if (rd_gnt) begin
      ram_req = rd_req;
    end
  end

endmodule

// File: hdl/cordic_rotator.sv
module cordic_rotator
  import slam_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rst,
  input  logic     rot_start,
  input  rot_req_t rot_in,
  output coord_t   rot_cos,
  output coord_t   rot_sin,
  output logic     rot_done
);

  // atan(2^-i) as a binary angle
  function automatic angle_t atan_lut(input logic [$clog2(CORDIC_ITER)-1:0] i);
    case (i)
      4'd0:    return 32'h2000_0000;
      4'd1:    return 32'h12E4_051E;
      4'd2:    return 32'h09FB_385B;
      4'd3:    return 32'h0511_11D4;
      4'd4:    return 32'h028B_0D43;
      4'd5:    return 32'h0145_D7E1;
      4'd6:    return 32'h00A2_F61E;
      4'd7:    return 32'h0051_7C55;
      4'd8:    return 32'h0028_BE53;
      4'd9:    return 32'h0014_5F2F;
      4'd10:   return 32'h000A_2F98;
      4'd11:   return 32'h0005_17CC;
      4'd12:   return 32'h0002_8BE6;
      4'd13:   return 32'h0001_45F3;
      4'd14:   return 32'h0000_A2FA;
      default: return 32'h0000_517D;
    endcase
  endfunction

  logic                           run_q, last_q, busy, load;
  logic [$clog2(CORDIC_ITER)-1:0] iter_q;
  coord_t                         x_q, y_q, x_sh, y_sh, mag_f;
  angle_t                         z_q, ang_f;
  logic                           fold;
  logic signed [49:0]             mag_scaled;

  assign busy = run_q | last_q;
  assign load = rot_start && !busy;

  // second and third quadrant turn by half a circle and flip the magnitude
  assign fold  = rot_in.ang[31] ^ rot_in.ang[30];
  assign mag_f = fold ? -rot_in.mag : rot_in.mag;
  assign ang_f = fold ? {~rot_in.ang[31], rot_in.ang[30:0]} : rot_in.ang;

  // pre-scale so the gain of the iterations cancels
  assign mag_scaled = mag_f * $signed({1'b0, CORDIC_GAIN_INV});

  assign x_sh = x_q >>> iter_q;
  assign y_sh = y_q >>> iter_q;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      run_q    <= 1'b0;
      last_q   <= 1'b0;
      rot_done <= 1'b0;
      iter_q   <= '0;
    end else begin
      rot_done <= last_q;
      last_q   <= run_q && (iter_q == CORDIC_ITER - 1);
      if (load) begin
        run_q  <= 1'b1;
        iter_q <= '0;
      end else if (run_q) begin
        iter_q <= iter_q + 1'b1;
        if (iter_q == CORDIC_ITER - 1) run_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      x_q <= mag_scaled[47:16];
      y_q <= '0;
      z_q <= ang_f;
    end else if (run_q) begin
      // drive the residual angle toward zero
      if (!z_q[31]) begin
        x_q <= x_q - y_sh;
        y_q <= y_q + x_sh;
        z_q <= z_q - atan_lut(iter_q);
      end else begin
        x_q <= x_q + y_sh;
        y_q <= y_q - x_sh;
        z_q <= z_q + atan_lut(iter_q);
      end
    end
    if (last_q) begin
      rot_cos <= x_q;
      rot_sin <= y_q;
    end
  end

endmodule

// File: hdl/state_readout.sv
module state_readout
  import slam_pkg::*;
(
  input  logic      clk,
  input  logic      sys_rst,
  input  logic      state_vector_start,
  input  lm_count_t landmark_num,
  output mem_req_t  rd_req,
  input  logic      rd_gnt,
  input  coord_t    ram_rdata,
  output coord_t    state_vector,
  output logic      state_vector_valid
);

  logic      active_q;
  mem_addr_t addr_q, last_addr;

  // theta is word 2, each landmark adds two
  assign last_addr = ADDR_THETA + {landmark_num, 1'b0};

  assign rd_req.en    = active_q;
  assign rd_req.we    = 1'b0;
  assign rd_req.addr  = addr_q;
  assign rd_req.wdata = '0;

  assign state_vector = ram_rdata;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      active_q           <= 1'b0;
      addr_q             <= ADDR_X;
      state_vector_valid <= 1'b0;
    end else begin
      // data of a granted read is on ram_rdata next cycle
      state_vector_valid <= rd_gnt;
      if (!active_q && state_vector_start) begin
        active_q <= 1'b1;
        addr_q   <= ADDR_X;
      end else if (active_q && rd_gnt) begin
        addr_q <= addr_q + 5'd1;
        if (addr_q == last_addr) active_q <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/stage_engine.sv
module stage_engine
  import slam_pkg::*;
(
  input  logic      clk,
  input  logic      sys_rst,
  input  logic      stage_start,
  input  stage_t    stage,
  input  coord_t    vlr,
  input  coord_t    rk,
  input  angle_t    alpha,
  input  angle_t    phi,
  output logic      stage_rdy,
  output lm_count_t landmark_num,
  output logic      rot_start,
  output rot_req_t  rot_in,
  input  coord_t    rot_cos,
  input  coord_t    rot_sin,
  input  logic      rot_done,
  output mem_req_t  eng_req,
  input  logic      eng_gnt,
  input  coord_t    ram_rdata
);

  typedef enum logic [3:0] {
    S_INIT_X, S_INIT_Y, S_INIT_T, S_IDLE,
    S_RD_X, S_RD_Y, S_RD_T, S_LOAD,
    S_ROT_GO, S_ROT_WAIT, S_LM_ADDR,
    S_WR_X, S_WR_Y, S_WR_T, S_FIN
  } eng_state_t;

  eng_state_t state_q, state_d;
  stage_t     stage_q;
  coord_t     x_q, y_q;
  angle_t     theta_q;
  mem_addr_t  lm_addr_q, ret_addr_q;
  logic       ret_vld_q;
  logic       is_prd;

  assign is_prd    = (stage_q == STAGE_PRD);
  assign stage_rdy = (state_q == S_IDLE);
  assign rot_start = (state_q == S_ROT_GO);
  assign rot_in.mag = is_prd ? vlr : rk;
  assign rot_in.ang = is_prd ? theta_q : theta_q + phi;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      S_INIT_X: if (eng_gnt) state_d = S_INIT_Y;
      S_INIT_Y: if (eng_gnt) state_d = S_INIT_T;
      S_INIT_T: if (eng_gnt) state_d = S_IDLE;
      S_IDLE: begin
        if (stage_start) begin
          // upd and assoc have no datapath here
          if (stage == STAGE_PRD || stage == STAGE_NEW) state_d = S_RD_X;
          else state_d = S_FIN;
        end
      end
      S_RD_X:   if (eng_gnt) state_d = S_RD_Y;
      S_RD_Y:   if (eng_gnt) state_d = S_RD_T;
      S_RD_T:   if (eng_gnt) state_d = S_LOAD;
      S_LOAD:   state_d = S_ROT_GO;
      S_ROT_GO: state_d = S_ROT_WAIT;
      S_ROT_WAIT: begin
        if (rot_done) begin
          if (is_prd) state_d = S_WR_X;
          else if (landmark_num < MAX_LANDMARKS) state_d = S_LM_ADDR;
          else state_d = S_FIN;
        end
      end
      S_LM_ADDR: state_d = S_WR_X;
      S_WR_X:    if (eng_gnt) state_d = S_WR_Y;
      S_WR_Y:    if (eng_gnt) state_d = is_prd ? S_WR_T : S_FIN;
      S_WR_T:    if (eng_gnt) state_d = S_FIN;
      default:   state_d = S_IDLE;
    endcase
  end

  always_comb begin
    eng_req = '0;
    unique case (state_q)
      S_INIT_X: eng_req = '{en: 1'b1, we: 1'b1, addr: ADDR_X, wdata: '0};
      S_INIT_Y: eng_req = '{en: 1'b1, we: 1'b1, addr: ADDR_Y, wdata: '0};
      S_INIT_T: eng_req = '{en: 1'b1, we: 1'b1, addr: ADDR_THETA, wdata: '0};
      S_RD_X:   eng_req = '{en: 1'b1, we: 1'b0, addr: ADDR_X, wdata: '0};
      S_RD_Y:   eng_req = '{en: 1'b1, we: 1'b0, addr: ADDR_Y, wdata: '0};
      S_RD_T:   eng_req = '{en: 1'b1, we: 1'b0, addr: ADDR_THETA, wdata: '0};
      S_WR_X: begin
        eng_req = '{en: 1'b1, we: 1'b1, addr: is_prd ? ADDR_X : lm_addr_q,
                    wdata: x_q + rot_cos};
      end
      S_WR_Y: begin
        eng_req = '{en: 1'b1, we: 1'b1,
                    addr: is_prd ? ADDR_Y : mem_addr_t'(lm_addr_q + 5'd1),
                    wdata: y_q + rot_sin};
      end
      S_WR_T: begin
        eng_req = '{en: 1'b1, we: 1'b1, addr: ADDR_THETA,
                    wdata: coord_t'(theta_q + alpha)};
      end
      default: eng_req = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state_q      <= S_INIT_X;
      landmark_num <= '0;
      ret_vld_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      ret_vld_q <= eng_gnt && !eng_req.we;
      // count moves once the landmark y word is in
      if (state_q == S_WR_Y && eng_gnt && !is_prd) landmark_num <= landmark_num + 4'd1;
    end
  end

  always_ff @(posedge clk) begin
    ret_addr_q <= eng_req.addr;
    if (state_q == S_IDLE && stage_start) stage_q <= stage;
    if (state_q == S_LM_ADDR) lm_addr_q <= ADDR_LM_BASE + {landmark_num, 1'b0};
    // read data lands one cycle after its grant
    if (ret_vld_q) begin
      case (ret_addr_q)
        ADDR_X:     x_q <= ram_rdata;
        ADDR_Y:     y_q <= ram_rdata;
        ADDR_THETA: theta_q <= angle_t'(ram_rdata);
        default:    ;
      endcase
    end
  end

endmodule

// File: hdl/slam_top.sv
module slam_top
  import slam_pkg::*;
(
  input  logic      clk,
  input  logic      sys_rst,
  input  stage_t    stage_val,
  output logic      stage_rdy,
  input  coord_t    vlr,
  input  angle_t    alpha,
  input  coord_t    rk,
  input  angle_t    phi,
  input  logic      state_vector_start,
  output coord_t    state_vector,
  output logic      state_vector_valid,
  output lm_count_t landmark_num
);

  stage_t   stage_val_q;
  logic     stage_start_q;
  logic     cmd_edge;
  coord_t   vlr_q, rk_q;
  angle_t   alpha_q, phi_q;

  rot_req_t rot_in;
  logic     rot_start, rot_done;
  coord_t   rot_cos, rot_sin;

  mem_req_t eng_req, rd_req, ram_req;
  logic     eng_gnt, rd_gnt;
  coord_t   ram_rdata;

  // a command starts when stage_val leaves idle
  assign cmd_edge = (stage_val != STAGE_IDLE) && (stage_val_q == STAGE_IDLE);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      stage_val_q   <= STAGE_IDLE;
      stage_start_q <= 1'b0;
    end else begin
      stage_val_q   <= stage_val;
      stage_start_q <= cmd_edge;
    end
  end

  // odometry for prediction, measurement for the rest
  always_ff @(posedge clk) begin
    if (cmd_edge) begin
      if (stage_val == STAGE_PRD) begin
        vlr_q   <= vlr;
        alpha_q <= alpha;
      end else begin
        rk_q  <= rk;
        phi_q <= phi;
      end
    end
  end

  stage_engine u_stage_engine (
    .clk, .sys_rst,
    .stage_start (stage_start_q),
    .stage       (stage_val_q),
    .vlr         (vlr_q),
    .rk          (rk_q),
    .alpha       (alpha_q),
    .phi         (phi_q),
    .stage_rdy, .landmark_num,
    .rot_start, .rot_in, .rot_cos, .rot_sin, .rot_done,
    .eng_req, .eng_gnt, .ram_rdata
  );

  cordic_rotator u_cordic_rotator (
    .clk, .sys_rst,
    .rot_start, .rot_in, .rot_cos, .rot_sin, .rot_done
  );

  state_mem_arbiter u_state_mem_arbiter (
    .clk, .sys_rst,
    .eng_req, .rd_req, .eng_gnt, .rd_gnt, .ram_req
  );

  state_ram u_state_ram (
    .clk, .ram_req, .ram_rdata
  );

  state_readout u_state_readout (
    .clk, .sys_rst,
    .state_vector_start, .landmark_num,
    .rd_req, .rd_gnt, .ram_rdata,
    .state_vector, .state_vector_valid
  );

endmodule

// File: testbench/slam_tb.sv
module slam_tb
  import slam_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int  NUM_TESTS = 18;
  localparam int  WATCHDOG_CYCLES = NUM_TESTS * 400 + 2000;
  localparam real TOL = 1.0 / 1024.0;
  localparam real PI = 3.14159265358979;

  // rd_mode 0 no readout, 1 readout after the command, 2 readout started with it
  typedef struct packed {
    stage_t     stage;
    coord_t     vlr;
    angle_t     alpha;
    coord_t     rk;
    angle_t     phi;
    logic [1:0] rd_mode;
  } test_entry_t;

  logic      clk;
  logic      sys_rst;
  stage_t    stage_val;
  logic      stage_rdy;
  coord_t    vlr, rk;
  angle_t    alpha, phi;
  logic      state_vector_start;
  coord_t    state_vector;
  logic      state_vector_valid;
  lm_count_t landmark_num;

  test_entry_t tests [NUM_TESTS];
  coord_t      rd_words [$];
  logic [31:0] rng_q;
  int          err_count;
  int          check_count;
  int          test_errs;

  // reference model of the state vector
  real    model_x, model_y;
  angle_t model_theta;
  real    model_lm_x [MAX_LANDMARKS];
  real    model_lm_y [MAX_LANDMARKS];
  int     model_count;

  slam_top u_slam_top (
    .clk, .sys_rst, .stage_val, .stage_rdy,
    .vlr, .alpha, .rk, .phi,
    .state_vector_start, .state_vector, .state_vector_valid, .landmark_num
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] r;
    r = s ^ (s << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  function automatic real q_to_real(input coord_t v);
    return real'(v) / 65536.0;
  endfunction

  // binary angle to radians, signed so the result sits in [-pi, pi)
  function automatic real ang_to_rad(input angle_t a);
    return real'($signed(a)) * 2.0 * PI / 4294967296.0;
  endfunction

  function automatic test_entry_t make_entry(input stage_t st, input coord_t v,
                                             input angle_t a, input coord_t r,
                                             input angle_t p, input logic [1:0] mode);
    return '{stage: st, vlr: v, alpha: a, rk: r, phi: p, rd_mode: mode};
  endfunction

  task automatic check_value(input string what, input real got, input real exp,
                             input real tol);
    real diff;
    diff = got - exp;
    if (diff < 0.0) diff = -diff;
    check_count++;
    if (diff > tol) begin
      $display("** Error at %0d ns: %s is %f, expected %f", $time, what, got, exp);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic build_table();
    coord_t rk_r;
    // prediction, including a negative step
    tests[0] = make_entry(STAGE_PRD, 32'sh0001_8000, 32'h1000_0000, '0, '0, 2'd1);
    tests[1] = make_entry(STAGE_PRD, 32'sh0000_C000, 32'h2000_0000, '0, '0, 2'd0);
    tests[2] = make_entry(STAGE_PRD, -32'sh0001_0000, 32'hE000_0000, '0, '0, 2'd1);
    // pure turns, theta wraps past a full turn again
    tests[3] = make_entry(STAGE_PRD, '0, 32'h9000_0001, '0, '0, 2'd0);
    tests[4] = make_entry(STAGE_PRD, '0, 32'h8000_0003, '0, '0, 2'd1);
    tests[5] = make_entry(STAGE_NEW, '0, '0, 32'sh0002_0000, 32'h4000_0000, 2'd1);
    tests[6] = make_entry(STAGE_UPD, '0, '0, 32'sh0001_0000, 32'h1234_5678, 2'd0);
    tests[7] = make_entry(STAGE_ASSOC, '0, '0, 32'sh0001_0000, 32'h0, 2'd1);
    // random landmarks, range 0.5 to 2.5
    for (int i = 8; i < 15; i++) begin
      rng_q = xorshift32(rng_q);
      rk_r = 32'sh0000_8000 + coord_t'(rng_q % 32'd131072);
      rng_q = xorshift32(rng_q);
      tests[i] = make_entry(STAGE_NEW, '0, '0, rk_r, rng_q, (i == 14) ? 2'd1 : 2'd0);
    end
    // ninth landmark finds the table full
    tests[15] = make_entry(STAGE_NEW, '0, '0, 32'sh0003_0000, 32'h0, 2'd1);
    tests[16] = make_entry(STAGE_PRD, 32'sh0000_8000, 32'h0800_0000, '0, '0, 2'd2);
    tests[17] = make_entry(STAGE_UPD, '0, '0, '0, '0, 2'd1);
  endtask

  task automatic apply_model(input test_entry_t t);
    real ang;
    if (t.stage == STAGE_PRD) begin
      ang = ang_to_rad(model_theta);
      model_x = model_x + q_to_real(t.vlr) * $cos(ang);
      model_y = model_y + q_to_real(t.vlr) * $sin(ang);
      model_theta = model_theta + t.alpha;
    end else if (t.stage == STAGE_NEW && model_count < MAX_LANDMARKS) begin
      ang = ang_to_rad(model_theta + t.phi);
      model_lm_x[model_count] = model_x + q_to_real(t.rk) * $cos(ang);
      model_lm_y[model_count] = model_y + q_to_real(t.rk) * $sin(ang);
      model_count++;
    end
  endtask

  task automatic issue_command(input test_entry_t t);
    while (!stage_rdy) @(negedge clk);
    @(posedge clk);
    #5;
    stage_val = t.stage;
    vlr = t.vlr;
    alpha = t.alpha;
    rk = t.rk;
    phi = t.phi;
    state_vector_start = (t.rd_mode == 2'd2);
    @(posedge clk);
    #5;
    state_vector_start = 1'b0;
    while (stage_rdy) @(negedge clk);
    while (!stage_rdy) @(negedge clk);
    @(posedge clk);
    #5;
    stage_val = STAGE_IDLE;
  endtask

  task automatic start_readout();
    @(posedge clk);
    #5;
    state_vector_start = 1'b1;
    @(posedge clk);
    #5;
    state_vector_start = 1'b0;
  endtask

  task automatic collect_readout(input int expected);
    rd_words.delete();
    while (rd_words.size() < expected) begin
      @(negedge clk);
      if (state_vector_valid) rd_words.push_back(state_vector);
    end
    // trailing words would mean a wrong length
    repeat (8) begin
      @(negedge clk);
      if (state_vector_valid) rd_words.push_back(state_vector);
    end
    check_value("readout length", real'(rd_words.size()), real'(expected), 0.0);
  endtask

  task automatic verify_readout(input logic check_pose);
    int k;
    if (check_pose && rd_words.size() >= 3) begin
      check_value("x", q_to_real(rd_words[0]), model_x, TOL);
      check_value("y", q_to_real(rd_words[1]), model_y, TOL);
      check_value("theta", real'(angle_t'(rd_words[2])), real'(model_theta), 0.0);
    end
    for (int i = 3; i < rd_words.size(); i++) begin
      k = (i - 3) / 2;
      if (k < model_count) begin
        if ((i - 3) % 2 == 0) check_value("landmark x", q_to_real(rd_words[i]),
                                          model_lm_x[k], TOL);
        else check_value("landmark y", q_to_real(rd_words[i]), model_lm_y[k], TOL);
      end
    end
  endtask

  initial begin
    int expected;
    sys_rst = 1'b1;
    stage_val = STAGE_IDLE;
    vlr = '0;
    alpha = '0;
    rk = '0;
    phi = '0;
    state_vector_start = 1'b0;
    err_count = 0;
    check_count = 0;
    test_errs = 0;
    model_x = 0.0;
    model_y = 0.0;
    model_theta = '0;
    model_count = 0;
    rng_q = 32'd54;
    build_table();
    repeat (2) @(posedge clk);
    #5;
    sys_rst = 1'b0;

    // pose words cleared by the init sequence
    while (!stage_rdy) @(negedge clk);
    start_readout();
    collect_readout(3);
    verify_readout(1'b1);
    $display("reset readout: %s", (test_errs == 0) ? "ok" : "failed");

    for (int i = 0; i < NUM_TESTS; i++) begin
      test_errs = 0;
      if (tests[i].rd_mode == 2'd2) begin
        expected = 3 + 2 * model_count;
        fork
          issue_command(tests[i]);
          collect_readout(expected);
        join
        apply_model(tests[i]);
        // pose words race the prediction, landmarks do not
        verify_readout(1'b0);
      end else begin
        issue_command(tests[i]);
        apply_model(tests[i]);
        if (tests[i].rd_mode == 2'd1) begin
          start_readout();
          collect_readout(3 + 2 * model_count);
          verify_readout(1'b1);
        end
      end
      check_value("landmark_num", real'(landmark_num), real'(model_count), 0.0);
      $display("test %0d (stage %0d): %s", i, tests[i].stage,
               (test_errs == 0) ? "ok" : "failed");
    end

    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS + 1, check_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: project.f
hdl/slam_pkg.sv
hdl/state_ram.sv
hdl/state_mem_arbiter.sv
hdl/cordic_rotator.sv
hdl/state_readout.sv
hdl/stage_engine.sv
hdl/slam_top.sv
testbench/slam_tb.sv
